//--- all.f
logic/sprite_pkg.sv
logic/sprite_serializer.sv
logic/sprite_overlap.sv
logic/sprite_data_hit.sv
logic/collision_latch.sv
logic/sprite_unit.sv
dv/sprite_unit_assertions.sv
dv/sprite_unit_tb.sv

//--- dv/sprite_unit_assertions.sv
`default_nettype none

module sprite_unit_assertions
    import sprite_pkg::*;
(
    input wire logic                   clk_dot4x,
    input wire logic                   rst,
    input wire logic                   phi_i,
    input wire logic                   m2m_clr_i,
    input wire logic                   m2d_clr_i,
    input wire logic [num_sprites-1:0] pending_m2m_i,
    input wire logic [num_sprites-1:0] pending_m2d_i,
    input wire logic [num_sprites-1:0] visible_m2m_i,
    input wire logic [num_sprites-1:0] visible_m2d_i,
    input wire logic                   immc_i,
    input wire logic                   imbc_i
);
    timeunit 1ns;
    timeprecision 1ps;

    // interrupt flags are only copied out during the low phase
    immc_rise_low: assert property (@(posedge clk_dot4x) disable iff (rst)
        $rose(immc_i) |-> !$past(phi_i))
        else $error("immc rose after a clock with phi high");
    imbc_rise_low: assert property (@(posedge clk_dot4x) disable iff (rst)
        $rose(imbc_i) |-> !$past(phi_i))
        else $error("imbc rose after a clock with phi high");

    // a register clear beats any collision on the same clock
    m2m_cleared: assert property (@(posedge clk_dot4x) disable iff (rst)
        m2m_clr_i |=> visible_m2m_i == '0)
        else $error("sprite to sprite mask not zero after its clear");
    m2d_cleared: assert property (@(posedge clk_dot4x) disable iff (rst)
        m2d_clr_i |=> visible_m2d_i == '0)
        else $error("sprite to data mask not zero after its clear");

    // pending bits are sticky
    m2m_sticky: assert property (@(posedge clk_dot4x) disable iff (rst)
        !m2m_clr_i |=> ($past(pending_m2m_i) & ~pending_m2m_i) == '0)
        else $error("sprite to sprite pending bit dropped without a clear");
    m2d_sticky: assert property (@(posedge clk_dot4x) disable iff (rst)
        !m2d_clr_i |=> ($past(pending_m2d_i) & ~pending_m2d_i) == '0)
        else $error("sprite to data pending bit dropped without a clear");

endmodule

bind collision_latch sprite_unit_assertions sprite_unit_assertions_inst (
    .clk_dot4x     (clk_dot4x),
    .rst           (rst),
    .phi_i         (phi_i),
    .m2m_clr_i     (m2m_clr_i),
    .m2d_clr_i     (m2d_clr_i),
    .pending_m2m_i (pending_q[0]),
    .pending_m2d_i (pending_q[1]),
    .visible_m2m_i (sprite_m2m_o),
    .visible_m2d_i (sprite_m2d_o),
    .immc_i        (immc_o),
    .imbc_i        (imbc_o)
);

`default_nettype wire

//--- dv/sprite_unit_tb.sv
`default_nettype none

module sprite_unit_tb
    import sprite_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int clk_period = 4;
    localparam int line_ticks = 128;
    localparam int num_lines = 15;
    // one line is its ticks, the byte loads and the flag checks around it
    localparam int line_clocks = (line_ticks + 1) * 4 + 3 * num_sprites + 40;
    localparam int watchdog_ns = num_lines * line_clocks * clk_period + 4000;

    logic                              clk_dot4x = 1'b0;
    logic                              rst;
    logic                              dot_tick_i;
    logic                              phi_i;
    logic [sprite_x_w-1:0]             xpos_i;
    logic [num_sprites*sprite_x_w-1:0] sprite_x_i;
    logic [num_sprites-1:0]            sprite_en_i;
    logic [num_sprites-1:0]            sprite_xe_i;
    logic [num_sprites-1:0]            sprite_mmc_i;
    logic                              load_i;
    logic [sprite_idx_w-1:0]           load_sprite_i;
    logic [byte_w-1:0]                 load_data_i;
    logic                              is_background_i;
    logic                              main_border_i;
    logic                              m2m_clr_i;
    logic                              m2d_clr_i;
    logic                              immc_clr_i;
    logic                              imbc_clr_i;
    logic [num_sprites*pixel_w-1:0]    sprite_pixel_o;
    logic [sprite_idx_w:0]             front_sprite_o;
    logic [num_sprites-1:0]            sprite_m2m_o;
    logic [num_sprites-1:0]            sprite_m2d_o;
    logic                              immc_o;
    logic                              imbc_o;

    // the three bytes last loaded into each sprite with the first byte on top
    logic [23:0] sprite_data [num_sprites];
    logic [31:0] lfsr_state = 32'hc0ea;
    int cyc = 0;
    int pixel_errors = 0;
    int flag_errors = 0;

    sprite_unit sprite_unit_inst (.*);

    initial begin
        forever #(clk_period / 2) clk_dot4x = ~clk_dot4x;
    end

    // galois form with taps at 32 30 26 and 25
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'ha3000000) : (s >> 1);
    endfunction

    // one lfsr step for every bit that is handed out
    function automatic logic [31:0] take_bits(input int count);
        logic [31:0] bits;
        bits = '0;
        for (int i = 0; i < count; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            bits = {bits[30:0], lfsr_state[0]};
        end
        return bits;
    endfunction

    // pixel a sprite shows age ticks after its x matched
    // a data bit lasts one tick, two when expanded, and a multicolor pair
    // covers two bit steps
    function automatic logic [1:0] expected_pixel(input logic [23:0] data, input logic xe,
            input logic mmc, input int age);
        int bit_step;
        int pair_idx;
        bit_step = xe ? age / 2 : age;
        if (bit_step >= 24) begin
            return 2'b00;
        end
        if (!mmc) begin
            return {data[23 - bit_step], 1'b0};
        end
        pair_idx = bit_step / 2;
        return data[23 - 2 * pair_idx -: 2];
    endfunction

    // inputs change on the falling edge, dot ticks come every fourth clock
    // and phi flips every sixteen clocks
    task automatic next_clock();
        @(negedge clk_dot4x);
        cyc++;
        dot_tick_i = (cyc % 4 == 0);
        if (cyc % 16 == 0) begin
            phi_i = !phi_i;
        end
        load_i = 1'b0;
        m2m_clr_i = 1'b0;
        m2d_clr_i = 1'b0;
        immc_clr_i = 1'b0;
        imbc_clr_i = 1'b0;
    endtask

    task automatic place_sprite(input int n, input logic [sprite_x_w-1:0] x, input logic en,
            input logic xe, input logic mmc);
        sprite_x_i[n*sprite_x_w +: sprite_x_w] = x;
        sprite_en_i[n] = en;
        sprite_xe_i[n] = xe;
        sprite_mmc_i[n] = mmc;
    endtask

    // of the three byte strobes the first ends up in the top data byte
    task automatic load_sprite(input int n, input logic [23:0] data);
        sprite_data[n] = data;
        for (int b = 2; b >= 0; b--) begin
            next_clock();
            load_i = 1'b1;
            load_sprite_i = n[sprite_idx_w-1:0];
            load_data_i = data[b*8 +: 8];
        end
    endtask

    // runs one raster line where border_at is the xpos at which the border
    // rises over non-background data, or -1 for a line without border
    task automatic run_line(input logic bg, input int border_at);
        int x_now;
        x_now = 0;
        is_background_i = bg;
        while (x_now < line_ticks) begin
            next_clock();
            if (dot_tick_i) begin
                xpos_i = x_now[sprite_x_w-1:0];
                if (x_now == border_at) begin
                    main_border_i = 1'b1;
                    is_background_i = 1'b0;
                end
                x_now++;
            end
        end
        next_clock();
        // park xpos where no sprite can match between lines
        xpos_i = '1;
        main_border_i = 1'b0;
        is_background_i = 1'b1;
    endtask

    // which is {imbc, immc, m2d, m2m}
    task automatic pulse_clears(input logic [3:0] which);
        next_clock();
        {imbc_clr_i, immc_clr_i, m2d_clr_i, m2m_clr_i} = which;
    endtask

    task automatic compare_value(input string name, input logic [31:0] got,
            input logic [31:0] want);
        assert (got == want) else begin
            $display("mismatch %s: got %h, expected %h", name, got, want);
            flag_errors++;
        end
    endtask

    // one phi period of 32 clocks always contains a full low window for the copy
    task automatic check_flags(input logic [num_sprites-1:0] want_m2m,
            input logic [num_sprites-1:0] want_m2d, input logic want_immc,
            input logic want_imbc);
        repeat (32) next_clock();
        compare_value("sprite_m2m_o", 32'(sprite_m2m_o), 32'(want_m2m));
        compare_value("sprite_m2d_o", 32'(sprite_m2d_o), 32'(want_m2d));
        compare_value("immc_o", 32'(immc_o), 32'(want_immc));
        compare_value("imbc_o", 32'(imbc_o), 32'(want_imbc));
    endtask

    // every sprite gets one of the four xe and mmc combinations per line
    task automatic random_line(input int line);
        int combo;
        logic [sprite_x_w-1:0] x;
        logic en;
        for (int n = 0; n < num_sprites; n++) begin
            combo = (n + line) % 4;
            x = sprite_x_w'(8 + take_bits(5));
            en = (take_bits(2) != 0);
            place_sprite(n, x, en, combo[0], combo[1]);
            load_sprite(n, 24'(take_bits(24)));
        end
        run_line(1'b1, -1);
    endtask

    // follows every sprite from its x match and checks each dot tick
    initial begin : compare_pixels
        int age [num_sprites];
        logic [num_sprites*pixel_w-1:0] exp_pix;
        logic [sprite_idx_w:0] exp_front;
        logic [sprite_x_w-1:0] xpos_seen;
        for (int n = 0; n < num_sprites; n++) begin
            age[n] = -1;
        end
        forever begin
            @(posedge clk_dot4x);
            if (dot_tick_i && !rst) begin
                xpos_seen = xpos_i;
                exp_front = '0;
                for (int n = num_sprites - 1; n >= 0; n--) begin
                    // xpos zero opens a new line and rearms every sprite
                    if (xpos_seen == '0) begin
                        age[n] = -1;
                    end
                    if (age[n] >= 0) begin
                        age[n]++;
                    end else if (sprite_en_i[n]
                            && sprite_x_i[n*sprite_x_w +: sprite_x_w] == xpos_seen) begin
                        age[n] = 0;
                    end
                    exp_pix[n*pixel_w +: pixel_w] = (age[n] >= 0) ? expected_pixel(
                        sprite_data[n], sprite_xe_i[n], sprite_mmc_i[n], age[n]) : 2'b00;
                    if (exp_pix[n*pixel_w +: pixel_w] != 2'b00) begin
                        exp_front = {1'b1, sprite_idx_w'(n)};
                    end
                end
                @(negedge clk_dot4x);
                assert (sprite_pixel_o == exp_pix) else begin
                    $display("mismatch sprite_pixel_o: got %h, expected %h at xpos %h",
                        sprite_pixel_o, exp_pix, xpos_seen);
                    pixel_errors++;
                end
                assert (front_sprite_o == exp_front) else begin
                    $display("mismatch front_sprite_o: got %h, expected %h at xpos %h",
                        front_sprite_o, exp_front, xpos_seen);
                    pixel_errors++;
                end
            end
        end
    end

    initial begin : watchdog
        #(watchdog_ns);
        $display("timeout: the tests did not reach their end in time");
        $display("Verification failed");
        $finish;
    end

    initial begin : stimulus
        rst = 1'b1;
        dot_tick_i = 1'b0;
        phi_i = 1'b0;
        xpos_i = '1;
        sprite_x_i = '0;
        sprite_en_i = '0;
        sprite_xe_i = '0;
        sprite_mmc_i = '0;
        load_i = 1'b0;
        load_sprite_i = '0;
        load_data_i = '0;
        is_background_i = 1'b1;
        main_border_i = 1'b0;
        m2m_clr_i = 1'b0;
        m2d_clr_i = 1'b0;
        immc_clr_i = 1'b0;
        imbc_clr_i = 1'b0;
        for (int n = 0; n < num_sprites; n++) begin
            sprite_data[n] = '0;
        end
        repeat (5) next_clock();
        rst = 1'b0;

        for (int line = 0; line < 8; line++) begin
            random_line(line);
        end

        // sprites 0 and 1 overlap fully while all others are off
        pulse_clears(4'b1111);
        place_sprite(0, 9'd20, 1'b1, 1'b0, 1'b0);
        place_sprite(1, 9'd20, 1'b1, 1'b0, 1'b0);
        sprite_en_i = 8'h03;
        load_sprite(0, 24'hffffff);
        load_sprite(1, 24'hffffff);
        run_line(1'b1, -1);
        check_flags(8'h03, 8'h00, 1'b1, 1'b0);
        // the interrupt stays quiet until the register itself is cleared
        pulse_clears(4'b0100);
        load_sprite(0, 24'hffffff);
        load_sprite(1, 24'hffffff);
        run_line(1'b1, -1);
        check_flags(8'h03, 8'h00, 1'b0, 1'b0);
        pulse_clears(4'b0001);
        check_flags(8'h00, 8'h00, 1'b0, 1'b0);
        load_sprite(0, 24'hffffff);
        load_sprite(1, 24'hffffff);
        run_line(1'b1, -1);
        check_flags(8'h03, 8'h00, 1'b1, 1'b0);

        // sprite 2 alone against the background and the border
        pulse_clears(4'b1111);
        place_sprite(2, 9'd30, 1'b1, 1'b0, 1'b0);
        sprite_en_i = 8'h04;
        load_sprite(2, 24'hffffff);
        run_line(1'b0, -1);
        check_flags(8'h00, 8'h04, 1'b0, 1'b1);
        pulse_clears(4'b1010);
        check_flags(8'h00, 8'h00, 1'b0, 1'b0);
        load_sprite(2, 24'hffffff);
        run_line(1'b1, -1);
        check_flags(8'h00, 8'h00, 1'b0, 1'b0);
        load_sprite(2, 24'hffffff);
        run_line(1'b1, 0);
        check_flags(8'h00, 8'h00, 1'b0, 1'b0);
        // only the clock where the border rises sees data under the sprite
        load_sprite(2, 24'hffffff);
        run_line(1'b1, 35);
        check_flags(8'h00, 8'h04, 1'b0, 1'b1);

        $display("errors: pixel %0d, collision %0d", pixel_errors, flag_errors);
        if (pixel_errors == 0 && flag_errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- logic/collision_latch.sv
`default_nettype none

// kind 0 is sprite to sprite, kind 1 is sprite to background data
module collision_latch
    import sprite_pkg::*;
(
    input  wire logic                   clk_dot4x,
    input  wire logic                   rst,
    input  wire logic                   phi_i,
    input  wire logic [num_sprites-1:0] overlap_i,
    input  wire logic [num_sprites-1:0] hit_i,
    input  wire logic                   m2m_clr_i,
    input  wire logic                   m2d_clr_i,
    input  wire logic                   immc_clr_i,
    input  wire logic                   imbc_clr_i,
    output logic [num_sprites-1:0]      sprite_m2m_o,
    output logic [num_sprites-1:0]      sprite_m2d_o,
    output logic                        immc_o,
    output logic                        imbc_o
);

    logic [num_sprites-1:0] mask [2];
    logic [num_sprites-1:0] pending_q [2];
    logic [num_sprites-1:0] visible_q [2];
    logic [1:0] clr;
    logic [1:0] irq_clr;
    logic [1:0] triggered_q;
    logic [1:0] irq_pending_q;
    logic [1:0] irq_q;

    assign mask[0] = overlap_i;
    assign mask[1] = hit_i;
    assign clr = {m2d_clr_i, m2m_clr_i};
    assign irq_clr = {imbc_clr_i, immc_clr_i};

    always_ff @(posedge clk_dot4x) begin
        if (rst) begin
            for (int k = 0; k < 2; k++) begin
                pending_q[k] <= '0;
                visible_q[k] <= '0;
            end
            triggered_q <= '0;
            irq_pending_q <= '0;
            irq_q <= '0;
        end else begin
            for (int k = 0; k < 2; k++) begin
                // collisions seen while phi is high only show up in the
                // next low phase
                if (!phi_i) begin
                    visible_q[k] <= pending_q[k];
                    irq_q[k] <= irq_pending_q[k];
                end
                // pending bits are sticky, only the first collision since
                // the last register clear requests an interrupt
                if (mask[k] != '0) begin
                    pending_q[k] <= pending_q[k] | mask[k];
                    if (!triggered_q[k]) begin
                        triggered_q[k] <= 1'b1;
                        irq_pending_q[k] <= 1'b1;
                    end
                end
                // clears come last so they win over a same clock collision
                if (irq_clr[k]) begin
                    irq_q[k] <= 1'b0;
                    irq_pending_q[k] <= 1'b0;
                end
                if (clr[k]) begin
                    pending_q[k] <= '0;
                    visible_q[k] <= '0;
                    triggered_q[k] <= 1'b0;
                end
            end
        end
    end

    assign sprite_m2m_o = visible_q[0];
    assign sprite_m2d_o = visible_q[1];
    assign immc_o = irq_q[0];
    assign imbc_o = irq_q[1];

endmodule

`default_nettype wire

//--- logic/sprite_data_hit.sv
`default_nettype none

module sprite_data_hit
    import sprite_pkg::*;
(
    input  wire logic                           clk_dot4x,
    input  wire logic                           rst,
    input  wire logic [num_sprites*pixel_w-1:0] pixel_i,
    input  wire logic [num_sprites-1:0]         sprite_mmc_i,
    input  wire logic                           is_background_i,
    input  wire logic                           main_border_i,
    output logic [num_sprites-1:0]              hit_o
);

    logic border_prev_q;
    logic border_rise;
    logic data_hit_ok;
    logic [pixel_w-1:0] pix;

    // previous border level at clock resolution
    always_ff @(posedge clk_dot4x) begin
        if (rst) begin
            border_prev_q <= 1'b0;
        end else begin
            border_prev_q <= main_border_i;
        end
    end

    // the last pixel of a line is already border but still collides,
    // so the rising edge of the border is let through
    assign border_rise = main_border_i && !border_prev_q;
    assign data_hit_ok = !is_background_i && (!main_border_i || border_rise);

    always_comb begin
        hit_o = '0;
        pix = '0;
        for (int n = 0; n < num_sprites; n++) begin
            pix = pixel_i[n*pixel_w +: pixel_w];
            // any nonzero multicolor code is opaque, in hires only the
            // upper bit carries the sprite bit
            if (sprite_mmc_i[n]) begin
                hit_o[n] = (pix != '0) && data_hit_ok;
            end else begin
                hit_o[n] = pix[1] && data_hit_ok;
            end
        end
    end

endmodule

`default_nettype wire

//--- logic/sprite_overlap.sv
`default_nettype none

module sprite_overlap
    import sprite_pkg::*;
(
    input  wire logic [num_sprites*pixel_w-1:0] pixel_i,
    output logic [num_sprites-1:0]              overlap_o,
    output logic [sprite_idx_w:0]               front_sprite_o
);

    // sprites that take part in sprite to sprite collisions
    logic [num_sprites-1:0] upper_mask;

    always_comb begin
        for (int n = 0; n < num_sprites; n++) begin
            upper_mask[n] = pixel_i[n*pixel_w + 1];
        end
    end

    // clearing the lowest set bit leaves something only when at least
    // two sprites overlap, a lone sprite never collides with itself
    assign overlap_o = ((upper_mask & (upper_mask - 1'b1)) != '0) ? upper_mask : '0;

    // lower numbers have higher priority, so scan downwards and let the
    // last hit win
    always_comb begin
        front_sprite_o = '0;
        for (int n = num_sprites - 1; n >= 0; n--) begin
            if (pixel_i[n*pixel_w +: pixel_w] != '0) begin
                front_sprite_o = {1'b1, sprite_idx_w'(n)};
            end
        end
    end

endmodule

`default_nettype wire

//--- logic/sprite_pkg.sv
`default_nettype none

package sprite_pkg;

    // number of hardware sprites handled by the unit
    localparam int num_sprites = 8;

    // x coordinates and the raster x position share one width
    localparam int sprite_x_w = 9;

    // one sprite pixel code, 00 means transparent
    localparam int pixel_w = 2;

    // three loaded bytes plus one byte of drift room above them
    localparam int shift_w = 32;
    localparam int byte_w = 8;

    // msb of the data still to be shown, just below the drift byte
    localparam int data_msb = shift_w - byte_w - 1;

    // index of one sprite, the front sprite output adds a valid bit on top
    localparam int sprite_idx_w = 3;

    // the top data byte is decoded either as eight hires bits or as
    // four multicolor pairs, pair 3 being the leftmost on screen
    typedef union packed {
        logic [byte_w-1:0] hires;
        logic [3:0][1:0] mc;
    } sprite_byte_u;

endpackage

`default_nettype wire

//--- logic/sprite_serializer.sv
`default_nettype none

// sprite n uses slice n of every flat vector with sprite 0 in the low bits
module sprite_serializer
    import sprite_pkg::*;
(
    input  wire logic                               clk_dot4x,
    input  wire logic                               rst,
    input  wire logic                               dot_tick_i,
    input  wire logic [sprite_x_w-1:0]              xpos_i,
    input  wire logic [num_sprites*sprite_x_w-1:0]  sprite_x_i,
    input  wire logic [num_sprites-1:0]             sprite_en_i,
    input  wire logic [num_sprites-1:0]             sprite_xe_i,
    input  wire logic [num_sprites-1:0]             sprite_mmc_i,
    input  wire logic                               load_i,
    input  wire logic [sprite_idx_w-1:0]            load_sprite_i,
    input  wire logic [byte_w-1:0]                  load_data_i,
    output logic [num_sprites*pixel_w-1:0]          pixel_o
);

    // the pixel register of each sprite is what the detectors see
    logic [shift_w-1:0] shift_q [num_sprites];
    logic [shift_w-1:0] shift_d [num_sprites];
    logic [pixel_w-1:0] pixel_q [num_sprites];
    logic [pixel_w-1:0] pixel_d [num_sprites];
    logic [num_sprites-1:0] active_q;
    logic [num_sprites-1:0] active_d;
    logic [num_sprites-1:0] xe_ff_q;
    logic [num_sprites-1:0] xe_ff_d;
    logic [num_sprites-1:0] mmc_ff_q;
    logic [num_sprites-1:0] mmc_ff_d;

    always_comb begin
        sprite_byte_u top_byte;
        logic match;
        for (int n = 0; n < num_sprites; n++) begin
            shift_d[n] = shift_q[n];
            pixel_d[n] = pixel_q[n];
            active_d[n] = active_q[n];
            xe_ff_d[n] = xe_ff_q[n];
            mmc_ff_d[n] = mmc_ff_q[n];
            top_byte = shift_q[n][data_msb -: byte_w];
            match = sprite_en_i[n] && !active_q[n]
                && (sprite_x_i[n*sprite_x_w +: sprite_x_w] == xpos_i);

            if (dot_tick_i) begin
                // an x match arms the sprite with both toggles set, and the
                // first pixel is produced in this same tick
                if (match) begin
                    active_d[n] = 1'b1;
                    xe_ff_d[n] = 1'b1;
                    mmc_ff_d[n] = 1'b1;
                end

                if (active_d[n]) begin
                    // keep going while data or a visible pixel remains
                    // the drift byte lets the last bits walk out of the window
                    if (shift_q[n] != '0 || pixel_q[n] != '0) begin
                        if (xe_ff_d[n]) begin
                            if (sprite_mmc_i[n]) begin
                                // a pair is taken on every other bit step
                                if (mmc_ff_d[n]) begin
                                    pixel_d[n] = top_byte.mc[3];
                                end
                                mmc_ff_d[n] = !mmc_ff_d[n];
                            end else begin
                                pixel_d[n] = {top_byte.hires[byte_w-1], 1'b0};
                            end
                            shift_d[n] = {shift_q[n][shift_w-2:0], 1'b0};
                        end
                        // with expansion each bit is held for two ticks
                        xe_ff_d[n] = sprite_xe_i[n] ? !xe_ff_d[n] : 1'b1;
                    end else begin
                        active_d[n] = 1'b0;
                        pixel_d[n] = '0;
                    end
                end
            end

            // a byte load pushes the older bytes up by one byte
            if (load_i && load_sprite_i == sprite_idx_w'(n)) begin
                shift_d[n] = {shift_q[n][shift_w-byte_w-1:0], load_data_i};
            end
        end
    end

    always_ff @(posedge clk_dot4x) begin
        if (rst) begin
            for (int n = 0; n < num_sprites; n++) begin
                shift_q[n] <= '0;
                pixel_q[n] <= '0;
            end
            active_q <= '0;
            xe_ff_q <= '1;
            mmc_ff_q <= '1;
        end else begin
            for (int n = 0; n < num_sprites; n++) begin
                shift_q[n] <= shift_d[n];
                pixel_q[n] <= pixel_d[n];
            end
            active_q <= active_d;
            xe_ff_q <= xe_ff_d;
            mmc_ff_q <= mmc_ff_d;
        end
    end

    // flatten the pixel registers for the detectors and the top level
    always_comb begin
        for (int n = 0; n < num_sprites; n++) begin
            pixel_o[n*pixel_w +: pixel_w] = pixel_q[n];
        end
    end

endmodule

`default_nettype wire

//--- logic/sprite_unit.sv
`default_nettype none

module sprite_unit
    import sprite_pkg::*;
(
    input  wire logic                               clk_dot4x,
    input  wire logic                               rst,
    input  wire logic                               dot_tick_i,
    input  wire logic                               phi_i,
    input  wire logic [sprite_x_w-1:0]              xpos_i,
    input  wire logic [num_sprites*sprite_x_w-1:0]  sprite_x_i,
    input  wire logic [num_sprites-1:0]             sprite_en_i,
    input  wire logic [num_sprites-1:0]             sprite_xe_i,
    input  wire logic [num_sprites-1:0]             sprite_mmc_i,
    input  wire logic                               load_i,
    input  wire logic [sprite_idx_w-1:0]            load_sprite_i,
    input  wire logic [byte_w-1:0]                  load_data_i,
    input  wire logic                               is_background_i,
    input  wire logic                               main_border_i,
    input  wire logic                               m2m_clr_i,
    input  wire logic                               m2d_clr_i,
    input  wire logic                               immc_clr_i,
    input  wire logic                               imbc_clr_i,
    output logic [num_sprites*pixel_w-1:0]          sprite_pixel_o,
    output logic [sprite_idx_w:0]                   front_sprite_o,
    output logic [num_sprites-1:0]                  sprite_m2m_o,
    output logic [num_sprites-1:0]                  sprite_m2d_o,
    output logic                                    immc_o,
    output logic                                    imbc_o
);

    // both detectors look at the same registered pixels
    logic [num_sprites-1:0] overlap;
    logic [num_sprites-1:0] hit;

    sprite_serializer sprite_serializer_inst (
        .clk_dot4x     (clk_dot4x),
        .rst           (rst),
        .dot_tick_i    (dot_tick_i),
        .xpos_i        (xpos_i),
        .sprite_x_i    (sprite_x_i),
        .sprite_en_i   (sprite_en_i),
        .sprite_xe_i   (sprite_xe_i),
        .sprite_mmc_i  (sprite_mmc_i),
        .load_i        (load_i),
        .load_sprite_i (load_sprite_i),
        .load_data_i   (load_data_i),
        .pixel_o       (sprite_pixel_o)
    );

    sprite_overlap sprite_overlap_inst (
        .pixel_i        (sprite_pixel_o),
        .overlap_o      (overlap),
        .front_sprite_o (front_sprite_o)
    );

    sprite_data_hit sprite_data_hit_inst (
        .clk_dot4x       (clk_dot4x),
        .rst             (rst),
        .pixel_i         (sprite_pixel_o),
        .sprite_mmc_i    (sprite_mmc_i),
        .is_background_i (is_background_i),
        .main_border_i   (main_border_i),
        .hit_o           (hit)
    );

    collision_latch collision_latch_inst (
        .clk_dot4x    (clk_dot4x),
        .rst          (rst),
        .phi_i        (phi_i),
        .overlap_i    (overlap),
        .hit_i        (hit),
        .m2m_clr_i    (m2m_clr_i),
        .m2d_clr_i    (m2d_clr_i),
        .immc_clr_i   (immc_clr_i),
        .imbc_clr_i   (imbc_clr_i),
        .sprite_m2m_o (sprite_m2m_o),
        .sprite_m2d_o (sprite_m2d_o),
        .immc_o       (immc_o),
        .imbc_o       (imbc_o)
    );

endmodule

`default_nettype wire

//--- run.sh
#!/bin/sh
# builds the sprite unit testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module sprite_unit_tb \
    -f all.f -Mdir obj_dir -o sprite_unit_sim
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/sprite_unit_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Verification failed" sim.log; then
    exit 1
fi
exit 0
